//--- compile.f
+incdir+common
common/core_pkg.sv
pipe_wb/core_load_align.sv
pipe_wb/core_pipe_wb.sv
verilog/core_gpr_file.sv
verilog/core_csr_file.sv
verilog/core_wb_top.sv
test/tb_core_wb_asserts.sv
test/tb_core_wb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the writeback testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_core_wb -o tb_core_wb
./obj_dir/tb_core_wb | tee sim.log

if grep -qx "Simulation PASSED" sim.log; then
    echo "run_sim: pass"
    exit 0
fi
echo "run_sim: fail"
exit 1

//--- test/tb_core_wb.sv
// Writeback end testbench
// Directed tests for execute writes, load alignment, CSR access, traps and
// retire counting through the core_wb_top ports

`timescale 1ns/1ps
`include "core_cfg.svh"

module tb_core_wb;

    import core_pkg::*;

    localparam int test_cyc    = 30 + 64 * 7 + 20 + 60 + 20;   // Rough cycles of all tests
    localparam int watchdog_ns = 2 * 40 * (5 + test_cyc);
    localparam logic [`CORE_CAUSE_W-1:0] cause_ill = `CORE_CAUSE_W'(`CAUSE_ILLEGAL);
    localparam logic [`CORE_CAUSE_W-1:0] cause_ldf = `CORE_CAUSE_W'(`CAUSE_LOAD_FAULT);
    localparam logic [`CORE_CAUSE_W-1:0] cause_brk = `CORE_CAUSE_W'(3);  // Upstream trap

    logic                       g_clk;
    logic                       g_resetn;
    logic                       s3_valid;
    logic                       s3_ready;
    s3_pkt_t                    s3_pkt;
    dmem_rsp_t                  dmem_rsp;
    logic [`CORE_REG_AW-1:0]    gpr_rd_addr;
    logic [`CORE_XLEN-1:0]      gpr_rd_data;
    rd_write_t                  gpr_wr;
    trap_t                      trap;
    trace_t                     trace;

    rd_write_t                  wr_s;                   // Sampled at the falling edge
    trap_t                      trap_s;
    trace_t                     trace_s;
    integer                     seed = 32'h1eb87173;
    logic [`CORE_XLEN-1:0]      pc_next = 64'h0000_0000_8000_0000;
    int                         errors = 0;
    int                         passed = 0;
    int                         failed = 0;
    int                         retired = 0;            // Expected minstret
    int                         wait_cycles;

    core_wb_top dut_i (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .s3_valid    (s3_valid),
        .s3_ready    (s3_ready),
        .s3_pkt      (s3_pkt),
        .dmem_rsp    (dmem_rsp),
        .gpr_rd_addr (gpr_rd_addr),
        .gpr_rd_data (gpr_rd_data),
        .gpr_wr      (gpr_wr),
        .trap        (trap),
        .trace       (trace)
    );

    always #20 g_clk = ~g_clk;

    // Compare tasks -----------------
    task automatic check_rd_write(string name, rd_write_t got, rd_write_t exp);
        if (got.wen !== exp.wen || (exp.wen && got !== exp)) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_trap(string name, trap_t got, trap_t exp);
        if (got.valid !== exp.valid || (exp.valid && got !== exp)) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_trace(string name, trace_t got, trace_t exp);
        if (got.valid !== exp.valid || (exp.valid && got !== exp)) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_data(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // Reference for the load aligner, built byte by byte
    function automatic logic [63:0] load_model(logic [63:0] word, int off, int size,
                                               logic sext);
        logic [63:0] val;
        int          nbytes;
        nbytes = 1 << size;
        val    = '0;
        for (int i = 0; i < nbytes; i++) begin
            if (off + i < 8) begin
                val[8*i +: 8] = word[8*(off+i) +: 8];
            end
        end
        if (sext && nbytes < 8 && val[8*nbytes-1]) begin
            for (int b = 8 * nbytes; b < 64; b++) begin
                val[b] = 1'b1;
            end
        end
        return val;
    endfunction

    function automatic s3_pkt_t make_pkt(wb_op_t op, logic [4:0] rd, logic [63:0] data);
        s3_pkt_t p;
        p       = '0;
        p.pc    = pc_next;
        p.instr = {pc_next[31:2], 2'b11};               // Unique per packet
        p.wdata = data;
        p.rd    = rd;
        p.wb_op = op;
        pc_next = pc_next + 64'd4;
        return p;
    endfunction

    // Stimulus ----------------------
    task automatic sample_step();
        @(negedge g_clk);
        wr_s    = gpr_wr;
        trap_s  = trap;
        trace_s = trace;
        @(posedge g_clk);
        #2;
    endtask

    // Snapshot holds the instruction leaving in the accept cycle
    task automatic offer(s3_pkt_t p);
        s3_valid    = 1'b1;
        s3_pkt      = p;
        wait_cycles = 0;
        @(negedge g_clk);
        while (!s3_ready) begin
            wait_cycles++;
            @(negedge g_clk);
        end
        wr_s    = gpr_wr;
        trap_s  = trap;
        trace_s = trace;
        @(posedge g_clk);
        #2;
        s3_valid = 1'b0;
    endtask

    task automatic run_load(s3_pkt_t p, logic [63:0] word, logic err);
        int delay;
        delay = $unsigned($random(seed)) % 4;
        offer(p);
        repeat (delay) begin
            @(negedge g_clk);
            check_data("s3_ready", 64'(s3_ready), 64'd0);
            check_data("trace.valid", 64'(trace.valid), 64'd0);
            @(posedge g_clk);
            #2;
        end
        dmem_rsp.gnt   = 1'b1;
        dmem_rsp.err   = err;
        dmem_rsp.rdata = word;
        sample_step();
        dmem_rsp = '0;
    endtask

    task automatic expect_done(s3_pkt_t p, logic wen, logic [63:0] data, logic tv,
                               logic [`CORE_CAUSE_W-1:0] cause, logic [63:0] mtval);
        rd_write_t ew;
        trap_t     et;
        trace_t    etr;
        ew.wen    = wen;
        ew.addr   = p.rd;
        ew.wdata  = data;
        et.valid  = tv;
        et.cause  = cause;
        et.mtval  = mtval;
        et.pc     = p.pc;
        etr.valid = 1'b1;
        etr.trap  = tv;
        etr.pc    = p.pc;
        etr.instr = p.instr;
        check_rd_write("gpr_wr", wr_s, ew);
        check_trap("trap", trap_s, et);
        check_trace("trace", trace_s, etr);
        if (!tv) begin
            retired++;
        end
    endtask

    task automatic expect_plain(s3_pkt_t q);
        expect_done(q, (q.wb_op != WB_NONE) && !q.trap, q.wdata, q.trap, q.trap_cause, 64'd0);
    endtask

    task automatic read_csr(logic [`CORE_CSR_AW-1:0] addr, logic [63:0] exp);
        s3_pkt_t p;
        p          = make_pkt(WB_CSR, 5'd31, 64'd0);
        p.csr_op   = CSR_RD;
        p.csr_addr = addr;
        offer(p);
        sample_step();
        expect_done(p, 1'b1, exp, 1'b0, '0, 64'd0);
    endtask

    task automatic check_trap_csrs(s3_pkt_t p, logic [`CORE_CAUSE_W-1:0] cause,
                                   logic [63:0] mtval);
        expect_done(p, 1'b0, 64'd0, 1'b1, cause, mtval);
        read_csr(`CSR_MEPC, p.pc);
        read_csr(`CSR_MCAUSE, 64'(cause));
        read_csr(`CSR_MTVAL, mtval);
    endtask

    task automatic report(string name, int start);
        if (errors == start) begin
            passed++;
            $display("%s: done, no errors", name);
        end else begin
            failed++;
            $display("%s: done, %0d errors", name, errors - start);
        end
    endtask

    // Tests -------------------------
    task automatic test_exec();
        int      start;
        s3_pkt_t p [8];
        start = errors;
        @(negedge g_clk);
        check_data("s3_ready after reset", 64'(s3_ready), 64'd1);
        check_rd_write("gpr_wr after reset", gpr_wr, '0);
        check_trap("trap after reset", trap, '0);
        check_trace("trace after reset", trace, '0);
        @(posedge g_clk);
        #2;
        for (int i = 0; i < 8; i++) begin
            p[i] = make_pkt(WB_WDATA, 5'((i + 1) % 8), {$random(seed), $random(seed)});
        end
        offer(p[0]);
        for (int i = 1; i < 8; i++) begin
            offer(p[i]);
            check_data("s3_ready wait cycles", 64'(wait_cycles), 64'd0);
            expect_plain(p[i-1]);
        end
        sample_step();
        expect_plain(p[7]);
        for (int i = 0; i < 8; i++) begin
            gpr_rd_addr = p[i].rd;
            @(negedge g_clk);
            check_data("gpr_rd_data", gpr_rd_data, (p[i].rd == 5'd0) ? 64'd0 : p[i].wdata);
            @(posedge g_clk);
            #2;
        end
        report("execute results", start);
    endtask

    task automatic test_load();
        int          start;
        s3_pkt_t     p;
        logic [63:0] word;
        start = errors;
        for (int sz = 0; sz < 4; sz++) begin
            for (int off = 0; off < 8; off++) begin
                for (int sx = 0; sx < 2; sx++) begin
                    word             = {$random(seed), $random(seed)};
                    p                = make_pkt(WB_LSU, 5'd10, 64'h8000_1000 | 64'(off));
                    p.lsu_op.load    = 1'b1;
                    p.lsu_op.sext    = sx[0];
                    p.lsu_op.size    = lsu_size_t'(sz);
                    run_load(p, word, 1'b0);
                    expect_done(p, 1'b1, load_model(word, off, sz, sx[0]), 1'b0, '0, 64'd0);
                end
            end
        end
        report("load alignment", start);
    endtask

    task automatic test_csr();
        int          start;
        s3_pkt_t     p;
        logic [63:0] ms;
        logic [63:0] v;
        csr_op_t     ops [4] = '{CSR_WR, CSR_SET, CSR_CLR, CSR_RD};
        start = errors;
        ms    = 64'd0;                                  // mscratch after reset
        for (int i = 0; i < 4; i++) begin
            v          = {$random(seed), $random(seed)};
            p          = make_pkt(WB_CSR, 5'(i + 11), v);
            p.csr_op   = ops[i];
            p.csr_addr = `CSR_MSCRATCH;
            offer(p);
            sample_step();
            expect_done(p, 1'b1, ms, 1'b0, '0, 64'd0); // Old value to rd
            case (ops[i])
                CSR_WR:  ms = v;
                CSR_SET: ms = ms | v;
                CSR_CLR: ms = ms & ~v;
                default: ms = ms;
            endcase
        end
        read_csr(`CSR_MSCRATCH, ms);
        report("CSR access", start);
    endtask

    task automatic test_trap();
        int      start;
        s3_pkt_t p;
        start = errors;
        p            = make_pkt(WB_WDATA, 5'd20, 64'h1234);
        p.trap       = 1'b1;
        p.trap_cause = cause_brk;
        offer(p);
        sample_step();
        check_trap_csrs(p, cause_brk, 64'd0);
        p          = make_pkt(WB_CSR, 5'd21, 64'd0);    // Unknown CSR
        p.csr_op   = CSR_RD;
        p.csr_addr = 12'h7c0;
        offer(p);
        sample_step();
        check_trap_csrs(p, cause_ill, 64'd0);
        p          = make_pkt(WB_CSR, 5'd22, 64'hffff);
        p.csr_op   = CSR_WR;
        p.csr_addr = `CSR_MISA;
        offer(p);
        sample_step();
        check_trap_csrs(p, cause_ill, 64'd0);
        read_csr(`CSR_MISA, `MISA_VALUE);               // misa unchanged
        p             = make_pkt(WB_LSU, 5'd23, 64'h9000_0ab8);
        p.lsu_op.load = 1'b1;
        p.lsu_op.size = LSU_DOUBLE;
        run_load(p, {$random(seed), $random(seed)}, 1'b1);
        check_trap_csrs(p, cause_ldf, p.wdata);
        report("traps", start);
    endtask

    task automatic test_retire();
        int      start;
        s3_pkt_t p [5];
        start = errors;
        for (int i = 0; i < 5; i++) begin
            p[i] = make_pkt(WB_WDATA, 5'(i + 24), {$random(seed), $random(seed)});
        end
        p[2].trap       = 1'b1;
        p[2].trap_cause = cause_brk;
        p[3].wb_op      = WB_NONE;
        offer(p[0]);
        for (int i = 1; i < 5; i++) begin
            offer(p[i]);
            expect_plain(p[i-1]);
        end
        sample_step();
        expect_plain(p[4]);
        read_csr(`CSR_MINSTRET, 64'(retired));
        report("retire and trace", start);
    endtask

    // Watchdog ----------------------
    initial begin
        #(watchdog_ns);
        $display("Timeout after %0d ns, the tests did not finish", watchdog_ns);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        g_clk       = 1'b0;
        g_resetn    = 1'b0;
        s3_valid    = 1'b0;
        s3_pkt      = '0;
        dmem_rsp    = '0;
        gpr_rd_addr = '0;
        repeat (5) @(posedge g_clk);
        #2;
        g_resetn = 1'b1;
        test_exec();
        test_load();
        test_csr();
        test_trap();
        test_retire();
        $display("Tests passed %0d, failed %0d, failed checks %0d", passed, failed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- test/tb_core_wb_asserts.sv
// Writeback stage assertions
// Occupancy, trap and load back-pressure rules checked against the stage handshake

`timescale 1ns/1ps

module tb_core_wb_asserts (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  logic                    s3_valid,
    input  logic                    s3_ready,
    input  core_pkg::s3_pkt_t       s3_pkt,
    input  core_pkg::dmem_rsp_t     dmem_rsp,
    input  core_pkg::rd_write_t     rd_wr,
    input  core_pkg::trap_t         trap,
    input  core_pkg::trace_t        trace
);

    // Port side occupancy -----------
    logic                   held;                   // Accepted and not yet traced
    logic                   held_load;
    logic                   held_trap;              // Upstream trap on the held packet

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            held <= 1'b0;
        end else if (s3_valid && s3_ready) begin
            held <= 1'b1;
        end else if (trace.valid) begin
            held <= 1'b0;
        end
    end

    always_ff @(posedge g_clk) begin
        if (s3_valid && s3_ready) begin
            held_load <= s3_pkt.lsu_op.load;
            held_trap <= s3_pkt.trap;
        end
    end

    trace_when_full: assert property (@(posedge g_clk) disable iff (!g_resetn)
        trace.valid |-> held)
        else $error("trace.valid raised while the stage is empty");

    // Trapped instructions never reach the GPRs
    no_write_on_trap: assert property (@(posedge g_clk) disable iff (!g_resetn)
        rd_wr.wen |-> !(trap.valid || held_trap))
        else $error("GPR write active for a trapped instruction");

    load_backpressure: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (held && held_load && !dmem_rsp.gnt) |-> !s3_ready)
        else $error("s3_ready high while a load waits for its grant");

endmodule

bind core_pipe_wb tb_core_wb_asserts asserts_i (
    .g_clk    (g_clk),
    .g_resetn (g_resetn),
    .s3_valid (s3_valid),
    .s3_ready (s3_ready),
    .s3_pkt   (s3_pkt),
    .dmem_rsp (dmem_rsp),
    .rd_wr    (rd_wr),
    .trap     (trap),
    .trace    (trace)
);

//--- verilog/core_wb_top.sv
// Writeback top level
// Connects the writeback stage to the GPR file and the machine CSR file

`timescale 1ns/1ps
`include "core_cfg.svh"

module core_wb_top (
    input  logic                        g_clk,
    input  logic                        g_resetn,
    input  logic                        s3_valid,
    output logic                        s3_ready,
    input  core_pkg::s3_pkt_t           s3_pkt,
    input  core_pkg::dmem_rsp_t         dmem_rsp,       // Load response level
    input  logic [`CORE_REG_AW-1:0]     gpr_rd_addr,    // Decode side read port
    output logic [`CORE_XLEN-1:0]       gpr_rd_data,
    output core_pkg::rd_write_t         gpr_wr,
    output core_pkg::trap_t             trap,
    output core_pkg::trace_t            trace
);

    import core_pkg::*;

    csr_req_t               csr_req;
    logic [`CORE_XLEN-1:0]  csr_rdata;
    logic                   csr_error;
    logic                   retire;

    core_pipe_wb pipe_wb_i (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .s3_valid  (s3_valid),
        .s3_ready  (s3_ready),
        .s3_pkt    (s3_pkt),
        .dmem_rsp  (dmem_rsp),
        .rd_wr     (gpr_wr),
        .csr_req   (csr_req),
        .csr_rdata (csr_rdata),
        .csr_error (csr_error),
        .trap      (trap),
        .retire    (retire),
        .trace     (trace)
    );

    core_gpr_file gpr_file_i (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .wr        (gpr_wr),
        .rd_addr   (gpr_rd_addr),
        .rd_data   (gpr_rd_data)
    );

    core_csr_file csr_file_i (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .req       (csr_req),
        .trap      (trap),
        .retire    (retire),
        .rdata     (csr_rdata),
        .error     (csr_error)
    );

endmodule

//--- verilog/core_csr_file.sv
// Machine mode CSR file
// mscratch, mepc, mcause, mtval, minstret and a fixed misa with read, write,
// set and clear access, trap capture and retired instruction counting

`timescale 1ns/1ps
`include "core_cfg.svh"

module core_csr_file (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  core_pkg::csr_req_t      req,
    input  core_pkg::trap_t         trap,
    input  logic                    retire,         // Instruction done, no trap
    output logic [`CORE_XLEN-1:0]   rdata,
    output logic                    error
);

    import core_pkg::*;

    logic [`CORE_XLEN-1:0]  mscratch;
    logic [`CORE_XLEN-1:0]  mepc;
    logic [`CORE_XLEN-1:0]  mcause;
    logic [`CORE_XLEN-1:0]  mtval;
    logic [`CORE_XLEN-1:0]  minstret;
    logic [`CORE_XLEN-1:0]  wval;
    logic                   known;
    logic                   modify;
    logic                   wr_en;

    // Read and decode ---------------
    always_comb begin
        known = 1'b1;
        case (req.addr)
            `CSR_MISA:     rdata = `MISA_VALUE;
            `CSR_MSCRATCH: rdata = mscratch;
            `CSR_MEPC:     rdata = mepc;
            `CSR_MCAUSE:   rdata = mcause;
            `CSR_MTVAL:    rdata = mtval;
            `CSR_MINSTRET: rdata = minstret;
            default: begin
                rdata = '0;
                known = 1'b0;
            end
        endcase
    end

    assign modify = (req.op == CSR_WR) || (req.op == CSR_SET) || (req.op == CSR_CLR);
    assign error  = req.en && (!known || (modify && req.addr == `CSR_MISA));
    assign wr_en  = req.en && modify && !trap.valid;    // Trap cancels the write

    always_comb begin
        case (req.op)
            CSR_WR:  wval = req.wdata;
            CSR_SET: wval = rdata | req.wdata;
            CSR_CLR: wval = rdata & ~req.wdata;
            default: wval = rdata;
        endcase
    end

    // Update ------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
            minstret <= '0;
        end else begin
            minstret <= minstret + `CORE_XLEN'(retire);
            if (trap.valid) begin
                mepc   <= trap.pc;
                mcause <= `CORE_XLEN'(trap.cause);      // Exceptions only, bit 63 clear
                mtval  <= trap.mtval;
            end else if (wr_en) begin
                case (req.addr)
                    `CSR_MSCRATCH: mscratch <= wval;
                    `CSR_MEPC:     mepc     <= wval;
                    `CSR_MCAUSE:   mcause   <= wval;
                    `CSR_MTVAL:    mtval    <= wval;
                    `CSR_MINSTRET: minstret <= wval;    // Overrides the increment
                    default:       mscratch <= mscratch;
                endcase
            end
        end
    end

endmodule

//--- verilog/core_gpr_file.sv
// General purpose register file
// 32 x 64 bit, one write port at the clock edge and one combinational read
// port, x0 hard wired to zero

`timescale 1ns/1ps
`include "core_cfg.svh"

module core_gpr_file (
    input  logic                        g_clk,
    input  logic                        g_resetn,
    input  core_pkg::rd_write_t         wr,         // Write from writeback
    input  logic [`CORE_REG_AW-1:0]     rd_addr,
    output logic [`CORE_XLEN-1:0]       rd_data
);

    import core_pkg::*;

    logic [`CORE_XLEN-1:0]  regs [`CORE_NREGS];
    logic                   wr_en;

    assign wr_en = wr.wen && (wr.addr != '0);       // Drop writes to x0

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 0; i < `CORE_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr.addr] <= wr.wdata;
        end
    end

    // Read port ---------------------
    always_comb begin
        if (rd_addr == '0) begin
            rd_data = '0;
        end else begin
            rd_data = regs[rd_addr];
        end
    end

endmodule

//--- pipe_wb/core_pipe_wb.sv
// Writeback stage
// Holds one instruction, selects the GPR write data, drives the CSR access,
// waits for load responses, raises traps and emits a trace record per instruction

`timescale 1ns/1ps
`include "core_cfg.svh"

module core_pipe_wb (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  logic                    s3_valid,       // New instruction offered
    output logic                    s3_ready,       // Stage can take it
    input  core_pkg::s3_pkt_t       s3_pkt,
    input  core_pkg::dmem_rsp_t     dmem_rsp,
    output core_pkg::rd_write_t     rd_wr,
    output core_pkg::csr_req_t      csr_req,
    input  logic [`CORE_XLEN-1:0]   csr_rdata,
    input  logic                    csr_error,
    output core_pkg::trap_t         trap,
    output logic                    retire,         // Completed without trap
    output core_pkg::trace_t        trace
);

    import core_pkg::*;

    // Packet holding ----------------
    s3_pkt_t                pkt;
    logic                   full;                   // Stage occupied
    logic                   is_load;
    logic                   done;                   // Instruction leaves this cycle
    logic                   accept;

    assign is_load  = pkt.lsu_op.load;
    assign done     = full && (!is_load || dmem_rsp.gnt);
    assign s3_ready = !full || done;
    assign accept   = s3_valid && s3_ready;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            full <= 1'b0;
        end else if (accept) begin
            full <= 1'b1;
        end else if (done) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge g_clk) begin
        if (accept) begin
            pkt <= s3_pkt;
        end
    end

    // Load data ---------------------
    logic [`CORE_XLEN-1:0]  load_data;

    core_load_align load_align_i (
        .rdata  (dmem_rsp.rdata),
        .offset (pkt.wdata[2:0]),                   // Low address bits
        .lsu_op (pkt.lsu_op),
        .data   (load_data)
    );

    // Traps -------------------------
    logic                   trap_csr;
    logic                   trap_load;
    logic                   trap_any;

    assign trap_csr  = csr_req.en && csr_error;
    assign trap_load = is_load && dmem_rsp.err;
    assign trap_any  = done && (pkt.trap || trap_csr || trap_load);

    always_comb begin
        trap.valid = trap_any;
        trap.pc    = pkt.pc;
        trap.mtval = '0;
        if (pkt.trap) begin
            trap.cause = pkt.trap_cause;
        end else if (trap_csr) begin
            trap.cause = `CORE_CAUSE_W'(`CAUSE_ILLEGAL);
        end else begin
            // Faulting load reports its address
            trap.cause = `CORE_CAUSE_W'(`CAUSE_LOAD_FAULT);
            trap.mtval = pkt.wdata;
        end
    end

    // CSR access --------------------
    assign csr_req.en    = done && (pkt.csr_op != CSR_NONE);
    assign csr_req.op    = pkt.csr_op;
    assign csr_req.addr  = pkt.csr_addr;
    assign csr_req.wdata = pkt.wdata;

    // GPR write ---------------------
    logic [`CORE_XLEN-1:0]  wb_data;

    always_comb begin
        case (pkt.wb_op)
            WB_WDATA: wb_data = pkt.wdata;
            WB_LSU:   wb_data = load_data;
            WB_CSR:   wb_data = csr_rdata;              // Value before the CSR write
            default:  wb_data = '0;
        endcase
    end

    assign rd_wr.wen   = done && !trap_any && (pkt.wb_op != WB_NONE);
    assign rd_wr.addr  = pkt.rd;
    assign rd_wr.wdata = wb_data;

    // Retire and trace --------------
    assign retire      = done && !trap_any;

    assign trace.valid = done;
    assign trace.trap  = trap_any;
    assign trace.pc    = pkt.pc;
    assign trace.instr = pkt.instr;

endmodule

//--- pipe_wb/core_load_align.sv
// Load data aligner
// Shifts the memory word down to the accessed byte, keeps the access size and
// sign or zero extends the result

`timescale 1ns/1ps
`include "core_cfg.svh"

module core_load_align (
    input  logic [`CORE_XLEN-1:0]   rdata,      // Raw memory word
    input  logic [2:0]              offset,     // Byte offset in the word
    input  core_pkg::lsu_op_t       lsu_op,
    output logic [`CORE_XLEN-1:0]   data
);

    import core_pkg::*;

    logic [`CORE_XLEN-1:0]  shifted;
    logic                   sign_b;
    logic                   sign_h;
    logic                   sign_w;

    assign shifted = rdata >> {offset, 3'b000};

    // Top bit of each size when extending signed
    assign sign_b  = lsu_op.sext && shifted[7];
    assign sign_h  = lsu_op.sext && shifted[15];
    assign sign_w  = lsu_op.sext && shifted[31];

    always_comb begin
        case (lsu_op.size)
            LSU_BYTE: begin
                data = {{(`CORE_XLEN-8){sign_b}}, shifted[7:0]};
            end
            LSU_HALF: begin
                data = {{(`CORE_XLEN-16){sign_h}}, shifted[15:0]};
            end
            LSU_WORD: begin
                data = {{(`CORE_XLEN-32){sign_w}}, shifted[31:0]};
            end
            default: begin
                data = shifted;                 // Full double word
            end
        endcase
    end

endmodule

//--- common/core_pkg.sv
// Core types
// Opcode enums and the packed structs passed between writeback, GPR and CSR blocks

`include "core_cfg.svh"

package core_pkg;

    // Opcodes ------------------------
    typedef enum logic [1:0] {
        WB_NONE,                                // No register write
        WB_WDATA,                               // Execute result
        WB_LSU,                                 // Aligned load data
        WB_CSR                                  // CSR read data
    } wb_op_t;

    typedef enum logic [2:0] {
        CSR_NONE,
        CSR_RD,
        CSR_WR,
        CSR_SET,
        CSR_CLR
    } csr_op_t;

    typedef enum logic [1:0] {
        LSU_BYTE,
        LSU_HALF,
        LSU_WORD,
        LSU_DOUBLE
    } lsu_size_t;

    typedef struct packed {
        logic                       load;       // Instruction is a load
        logic                       sext;       // Sign extend the result
        lsu_size_t                  size;
    } lsu_op_t;

    // Stage traffic -----------------
    typedef struct packed {
        logic [`CORE_XLEN-1:0]      pc;
        logic [31:0]                instr;
        logic [`CORE_XLEN-1:0]      wdata;      // Result, load address or CSR operand
        logic [`CORE_REG_AW-1:0]    rd;
        wb_op_t                     wb_op;
        lsu_op_t                    lsu_op;
        csr_op_t                    csr_op;
        logic [`CORE_CSR_AW-1:0]    csr_addr;
        logic                       trap;       // Trap raised upstream
        logic [`CORE_CAUSE_W-1:0]   trap_cause;
    } s3_pkt_t;

    typedef struct packed {
        logic                       gnt;        // Response valid
        logic                       err;
        logic [`CORE_XLEN-1:0]      rdata;
    } dmem_rsp_t;

    typedef struct packed {
        logic                       wen;
        logic [`CORE_REG_AW-1:0]    addr;
        logic [`CORE_XLEN-1:0]      wdata;
    } rd_write_t;

    typedef struct packed {
        logic                       en;
        csr_op_t                    op;
        logic [`CORE_CSR_AW-1:0]    addr;
        logic [`CORE_XLEN-1:0]      wdata;
    } csr_req_t;

    typedef struct packed {
        logic                       valid;
        logic [`CORE_CAUSE_W-1:0]   cause;
        logic [`CORE_XLEN-1:0]      mtval;
        logic [`CORE_XLEN-1:0]      pc;
    } trap_t;

    typedef struct packed {
        logic                       valid;      // One pulse per instruction leaving
        logic                       trap;
        logic [`CORE_XLEN-1:0]      pc;
        logic [31:0]                instr;
    } trace_t;

endpackage

//--- common/core_cfg.svh
// Core configuration
// Data and address widths, CSR map and trap cause codes for the writeback end

`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Widths ------------------------
`define CORE_XLEN        64         // Data path width
`define CORE_REG_AW      5          // GPR address bits
`define CORE_NREGS       32         // Number of GPRs
`define CORE_CSR_AW      12         // CSR address bits
`define CORE_CAUSE_W     6          // Trap cause bits

// CSR map -----------------------
`define CSR_MISA         12'h301
`define CSR_MSCRATCH     12'h340
`define CSR_MEPC         12'h341
`define CSR_MCAUSE       12'h342
`define CSR_MTVAL        12'h343
`define CSR_MINSTRET     12'hB02
`define MISA_VALUE       64'h8000_0000_0000_0100 // MXL=2, I extension

// Trap causes -------------------
`define CAUSE_ILLEGAL    2          // Illegal instruction
`define CAUSE_LOAD_FAULT 5          // Load access fault

`endif
